// ==== logic/tag_link_pkg.sv ====
////////////////////
// Shared widths, register map and tag word layout
// for the time tagger receive link
////////////////////

package tag_link_pkg;

    // Stream geometry
    localparam int WORD_WIDTH     = 2;
    localparam int TAG_BITS       = 32;
    localparam int WRAP_BITS      = 32;
    localparam int TIME_BITS      = 64;
    localparam int SUBTIME_BITS   = 25;
    localparam int CHANNEL_BITS   = 5;
    localparam int LANE_SUM_BITS  = $clog2(WORD_WIDTH + 1);

    // User block
    localparam int COUNT_CHANNELS = 8;
    localparam int COUNT_SEL_BITS = $clog2(COUNT_CHANNELS);
    localparam int LED_COUNT      = 6;

    // Register bus, top two address bits pick the slave
    localparam int WB_ADR_BITS    = 8;
    localparam int WB_OFFSET_BITS = 6;
    localparam int WB_DATA_BITS   = 32;

    localparam logic [1:0] SEL_CONVERTER = 2'd0;
    localparam logic [1:0] SEL_COUNTER   = 2'd1;

    localparam logic [WB_OFFSET_BITS-1:0] CONV_REG_MISSED = 6'd0;
    localparam logic [WB_OFFSET_BITS-1:0] CONV_REG_WRAP   = 6'd1;
    localparam logic [WB_OFFSET_BITS-1:0] CNT_REG_CONTROL = 6'd8;

    // Event view of a tag word, kind bit clear
    typedef struct packed {
        logic                    kind;
        logic                    rising;
        logic [CHANNEL_BITS-1:0] channel;
        logic [SUBTIME_BITS-1:0] subtime;
    } tag_event_t;

    // Missed-event marker, kind bit set
    typedef struct packed {
        logic                kind;
        logic [TAG_BITS-2:0] missed;
    } tag_marker_t;

    typedef union packed {
        tag_event_t  ev;
        tag_marker_t mk;
    } tag_word_u;

endpackage

// ==== logic/tag_event_if.sv ====
////////////////////
// Converted event stream, one beat carries
// up to WORD_WIDTH events
////////////////////

`timescale 1ns/1ps

interface tag_event_if import tag_link_pkg::*; ();

    logic                                    valid;
    logic                                    ready;
    logic [WORD_WIDTH-1:0]                   keep;
    logic [WORD_WIDTH-1:0][CHANNEL_BITS-1:0] channel;
    logic [WORD_WIDTH-1:0]                   rising;
    logic [WORD_WIDTH-1:0][TIME_BITS-1:0]    tagtime;

    modport conv (
        output valid, keep, channel, rising, tagtime,
        input  ready
    );

    modport cnt (
        input  valid, keep, channel, rising, tagtime,
        output ready
    );

endinterface

// ==== logic/wb_bus_if.sv ====
////////////////////
// One Wishbone slave port behind the decoder
////////////////////

`timescale 1ns/1ps

interface wb_bus_if import tag_link_pkg::*; ();

    logic                      cyc;
    logic                      stb;
    logic                      we;
    logic [WB_OFFSET_BITS-1:0] adr;
    logic [WB_DATA_BITS-1:0]   dat_w;
    logic [WB_DATA_BITS-1:0]   dat_r;
    logic                      ack;

    modport dec (
        output cyc, stb, we, adr, dat_w,
        input  dat_r, ack
    );

    modport slv (
        input  cyc, stb, we, adr, dat_w,
        output dat_r, ack
    );

endinterface

// ==== logic/tag_converter.sv ====
////////////////////
// Tag word converter: splits words into events and
// missed-event markers, keeps the marker total and
// the last event wrap count for the register bus
////////////////////

`timescale 1ns/1ps

module tag_converter import tag_link_pkg::*; (
    input  logic                           okClk,
    input  logic                           rst_n_i,
    input  logic                           s_tvalid_i,
    input  logic [WORD_WIDTH*TAG_BITS-1:0] s_tdata_i,
    input  logic [WORD_WIDTH-1:0]          s_tkeep_i,
    input  logic [WRAP_BITS-1:0]           s_tuser_i,
    output logic                           s_tready_o,
    tag_event_if.conv                      evt,
    wb_bus_if.slv                          wb
);

    tag_word_u [WORD_WIDTH-1:0] word;
    logic      [WORD_WIDTH-1:0] event_keep;
    logic      [WB_DATA_BITS-1:0] marker_sum;
    logic      [WB_DATA_BITS-1:0] missed_total;
    logic      [WRAP_BITS-1:0]    last_wrap;
    logic                         accept;

    // Lane 0 sits in the low half of the beat
    assign word = s_tdata_i;

    // Single output register, refilled in the cycle it drains
    assign s_tready_o = !evt.valid || evt.ready;
    assign accept     = s_tvalid_i && s_tready_o;

    always_comb begin
        marker_sum = '0;
        for (int i = 0; i < WORD_WIDTH; i++) begin
            event_keep[i] = s_tkeep_i[i] && !word[i].ev.kind;
            if (s_tkeep_i[i] && word[i].mk.kind) begin
                marker_sum = marker_sum + WB_DATA_BITS'(word[i].mk.missed);
            end
        end
    end

    always_ff @(posedge okClk) begin
        if (!rst_n_i) begin
            evt.valid <= 1'b0;
        end else if (accept) begin
            // Beats made only of markers leave no output beat
            evt.valid <= |event_keep;
        end else if (evt.ready) begin
            evt.valid <= 1'b0;
        end
    end

    always_ff @(posedge okClk) begin
        if (accept && |event_keep) begin
            evt.keep <= event_keep;
            for (int i = 0; i < WORD_WIDTH; i++) begin
                evt.channel[i] <= word[i].ev.channel;
                evt.rising[i]  <= word[i].ev.rising;
                // Wrap count above the fine time, zero-extended
                evt.tagtime[i] <= TIME_BITS'({s_tuser_i, word[i].ev.subtime});
            end
        end
    end

    always_ff @(posedge okClk) begin
        if (!rst_n_i) begin
            missed_total <= '0;
            last_wrap    <= '0;
        end else if (accept) begin
            missed_total <= missed_total + marker_sum;
            if (|event_keep) begin
                last_wrap <= s_tuser_i;
            end
        end
    end

    // Read-only status registers, one cycle ack
    always_ff @(posedge okClk) begin
        if (!rst_n_i) begin
            wb.ack <= 1'b0;
        end else begin
            wb.ack <= wb.cyc && wb.stb && !wb.ack;
        end
    end

    always_comb begin
        case (wb.adr)
            CONV_REG_MISSED: wb.dat_r = missed_total;
            CONV_REG_WRAP:   wb.dat_r = last_wrap;
            default:         wb.dat_r = '0;
        endcase
    end

endmodule

// ==== logic/edge_counter.sv ====
////////////////////
// Rising edge counter per channel with LED
// display, stream hold and count clear
////////////////////

`timescale 1ns/1ps

module edge_counter import tag_link_pkg::*; (
    input  logic                 okClk,
    input  logic                 rst_n_i,
    tag_event_if.cnt             evt,
    wb_bus_if.slv                wb,
    output logic [LED_COUNT-1:0] led_o
);

    logic [WB_DATA_BITS-1:0]  counts [COUNT_CHANNELS];
    logic [LANE_SUM_BITS-1:0] inc    [COUNT_CHANNELS];
    logic                     hold;
    logic                     transfer;
    logic                     wr_ctrl;
    logic                     clear;

    assign evt.ready = !hold;
    assign transfer  = evt.valid && evt.ready;

    // Control write lands in the first cycle of the access
    assign wr_ctrl = wb.cyc && wb.stb && wb.we && !wb.ack && (wb.adr == CNT_REG_CONTROL);
    assign clear   = wr_ctrl && wb.dat_w[1];

    // Lanes on the same channel both count
    always_comb begin
        for (int c = 0; c < COUNT_CHANNELS; c++) begin
            inc[c] = '0;
            for (int i = 0; i < WORD_WIDTH; i++) begin
                if (evt.keep[i] && evt.rising[i] &&
                    evt.channel[i] == CHANNEL_BITS'(c)) begin
                    inc[c] = inc[c] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge okClk) begin
        if (!rst_n_i || clear) begin
            for (int c = 0; c < COUNT_CHANNELS; c++) begin
                counts[c] <= '0;
            end
        end else if (transfer) begin
            for (int c = 0; c < COUNT_CHANNELS; c++) begin
                counts[c] <= counts[c] + WB_DATA_BITS'(inc[c]);
            end
        end
    end

    always_ff @(posedge okClk) begin
        if (!rst_n_i) begin
            hold <= 1'b0;
        end else if (wr_ctrl) begin
            hold <= wb.dat_w[0];
        end
    end

    always_ff @(posedge okClk) begin
        if (!rst_n_i) begin
            wb.ack <= 1'b0;
        end else begin
            wb.ack <= wb.cyc && wb.stb && !wb.ack;
        end
    end

    // Clear bit is a strobe and reads back as zero
    always_comb begin
        wb.dat_r = '0;
        if (wb.adr < WB_OFFSET_BITS'(COUNT_CHANNELS)) begin
            wb.dat_r = counts[wb.adr[COUNT_SEL_BITS-1:0]];
        end else if (wb.adr == CNT_REG_CONTROL) begin
            wb.dat_r[0] = hold;
        end
    end

    for (genvar i = 0; i < LED_COUNT; i++) begin : g_led
        assign led_o[i] = |counts[i];
    end

endmodule

// ==== logic/wb_decoder.sv ====
////////////////////
// Wishbone address decoder with always-ack
// answer for unmapped slave selects
////////////////////

`timescale 1ns/1ps

module wb_decoder import tag_link_pkg::*; (
    input  logic                    okClk,
    input  logic                    rst_n_i,
    input  logic                    wb_cyc_i,
    input  logic                    wb_stb_i,
    input  logic                    wb_we_i,
    input  logic [WB_ADR_BITS-1:0]  wb_adr_i,
    input  logic [WB_DATA_BITS-1:0] wb_dat_i,
    output logic [WB_DATA_BITS-1:0] wb_dat_o,
    output logic                    wb_ack_o,
    wb_bus_if.dec                   conv,
    wb_bus_if.dec                   cnt
);

    logic [1:0] sel;
    logic       unmapped;
    logic       unmapped_ack;

    assign sel      = wb_adr_i[WB_ADR_BITS-1:WB_OFFSET_BITS];
    assign unmapped = (sel != SEL_CONVERTER) && (sel != SEL_COUNTER);

    assign conv.cyc   = wb_cyc_i && (sel == SEL_CONVERTER);
    assign conv.stb   = wb_stb_i && (sel == SEL_CONVERTER);
    assign conv.we    = wb_we_i;
    assign conv.adr   = wb_adr_i[WB_OFFSET_BITS-1:0];
    assign conv.dat_w = wb_dat_i;

    assign cnt.cyc    = wb_cyc_i && (sel == SEL_COUNTER);
    assign cnt.stb    = wb_stb_i && (sel == SEL_COUNTER);
    assign cnt.we     = wb_we_i;
    assign cnt.adr    = wb_adr_i[WB_OFFSET_BITS-1:0];
    assign cnt.dat_w  = wb_dat_i;

    // Keeps the bus alive for addresses nobody owns
    always_ff @(posedge okClk) begin
        if (!rst_n_i) begin
            unmapped_ack <= 1'b0;
        end else begin
            unmapped_ack <= wb_cyc_i && wb_stb_i && unmapped && !unmapped_ack;
        end
    end

    always_comb begin
        case (sel)
            SEL_CONVERTER: begin
                wb_dat_o = conv.dat_r;
                wb_ack_o = conv.ack;
            end
            SEL_COUNTER: begin
                wb_dat_o = cnt.dat_r;
                wb_ack_o = cnt.ack;
            end
            default: begin
                wb_dat_o = '0;
                wb_ack_o = unmapped_ack;
            end
        endcase
    end

endmodule

// ==== logic/tag_link_top.sv ====
////////////////////
// Receive side of the tag link: converter,
// edge counter and register decoder
////////////////////

`timescale 1ns/1ps

module tag_link_top import tag_link_pkg::*; (
    input  logic                           okClk,
    input  logic                           rst_n_i,
    // Tag stream
    input  logic                           s_tvalid_i,
    output logic                           s_tready_o,
    input  logic [WORD_WIDTH*TAG_BITS-1:0] s_tdata_i,
    input  logic [WORD_WIDTH-1:0]          s_tkeep_i,
    input  logic [WRAP_BITS-1:0]           s_tuser_i,
    // Register bus
    input  logic                           wb_cyc_i,
    input  logic                           wb_stb_i,
    input  logic                           wb_we_i,
    input  logic [WB_ADR_BITS-1:0]         wb_adr_i,
    input  logic [WB_DATA_BITS-1:0]        wb_dat_i,
    output logic [WB_DATA_BITS-1:0]        wb_dat_o,
    output logic                           wb_ack_o,
    output logic [LED_COUNT-1:0]           led_o
);

    tag_event_if evt_if ();
    wb_bus_if    conv_wb ();
    wb_bus_if    cnt_wb ();

    tag_converter tag_converter_i (
        .okClk      (okClk),
        .rst_n_i    (rst_n_i),
        .s_tvalid_i (s_tvalid_i),
        .s_tdata_i  (s_tdata_i),
        .s_tkeep_i  (s_tkeep_i),
        .s_tuser_i  (s_tuser_i),
        .s_tready_o (s_tready_o),
        .evt        (evt_if.conv),
        .wb         (conv_wb.slv)
    );

    edge_counter edge_counter_i (
        .okClk   (okClk),
        .rst_n_i (rst_n_i),
        .evt     (evt_if.cnt),
        .wb      (cnt_wb.slv),
        .led_o   (led_o)
    );

    wb_decoder wb_decoder_i (
        .okClk    (okClk),
        .rst_n_i  (rst_n_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o),
        .conv     (conv_wb.dec),
        .cnt      (cnt_wb.dec)
    );

endmodule

// ==== verif/tag_link_asserts.sv ====
////////////////////
// Register and count model of the link, with
// concurrent checks bound to tag_link_top
////////////////////

`timescale 1ns/1ps

module tag_link_asserts import tag_link_pkg::*; (
    input logic                           okClk,
    input logic                           rst_n_i,
    input logic                           s_tvalid_i,
    input logic                           s_tready_o,
    input logic [WORD_WIDTH*TAG_BITS-1:0] s_tdata_i,
    input logic [WORD_WIDTH-1:0]          s_tkeep_i,
    input logic [WRAP_BITS-1:0]           s_tuser_i,
    input logic                           wb_cyc_i,
    input logic                           wb_stb_i,
    input logic                           wb_we_i,
    input logic [WB_ADR_BITS-1:0]         wb_adr_i,
    input logic [WB_DATA_BITS-1:0]        wb_dat_i,
    input logic [WB_DATA_BITS-1:0]        wb_dat_o,
    input logic                           wb_ack_o,
    input logic [LED_COUNT-1:0]           led_o
);

    int unsigned error_count = 0;

    logic [WB_DATA_BITS-1:0] model_cnt [COUNT_CHANNELS];
    logic [WB_DATA_BITS-1:0] pend_inc  [COUNT_CHANNELS];
    logic [WB_DATA_BITS-1:0] beat_inc  [COUNT_CHANNELS];
    logic                    pend_valid;
    logic                    model_hold;
    logic [WB_DATA_BITS-1:0] model_missed;
    logic [WRAP_BITS-1:0]    model_wrap;
    logic [WB_DATA_BITS-1:0] beat_missed;
    logic                    beat_has_event;
    logic [TAG_BITS-1:0]     lane;
    logic                    accepted;
    logic                    drain;
    logic                    ctrl_write;
    logic [WB_DATA_BITS-1:0] exp_rd;
    logic [LED_COUNT-1:0]    exp_led;

    assign accepted   = s_tvalid_i && s_tready_o;
    // Parked beat moves on to the counter whenever hold is clear
    assign drain      = pend_valid && !model_hold;
    assign ctrl_write = wb_cyc_i && wb_stb_i && wb_we_i && !wb_ack_o &&
                        (wb_adr_i == {SEL_COUNTER, CNT_REG_CONTROL});

    // Tally of one input beat: bit 31 marker, bit 30 rising, bits 29:25 channel
    always_comb begin
        beat_missed    = '0;
        beat_has_event = 1'b0;
        lane           = '0;
        for (int c = 0; c < COUNT_CHANNELS; c++) begin
            beat_inc[c] = '0;
        end
        for (int i = 0; i < WORD_WIDTH; i++) begin
            lane = s_tdata_i[i*TAG_BITS +: TAG_BITS];
            if (s_tkeep_i[i] && lane[31]) begin
                beat_missed = beat_missed + {1'b0, lane[30:0]};
            end else if (s_tkeep_i[i]) begin
                beat_has_event = 1'b1;
                if (lane[30] && lane[29:25] < 5'(COUNT_CHANNELS)) begin
                    beat_inc[lane[27:25]] = beat_inc[lane[27:25]] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge okClk) begin
        if (!rst_n_i) begin
            pend_valid   <= 1'b0;
            model_hold   <= 1'b0;
            model_missed <= '0;
            model_wrap   <= '0;
            for (int c = 0; c < COUNT_CHANNELS; c++) begin
                model_cnt[c] <= '0;
                pend_inc[c]  <= '0;
            end
        end else begin
            if (ctrl_write) begin
                model_hold <= wb_dat_i[0];
            end
            if (drain) begin
                pend_valid <= 1'b0;
            end
            if (accepted) begin
                model_missed <= model_missed + beat_missed;
                if (beat_has_event) begin
                    pend_valid <= 1'b1;
                    model_wrap <= s_tuser_i;
                    for (int c = 0; c < COUNT_CHANNELS; c++) begin
                        pend_inc[c] <= beat_inc[c];
                    end
                end
            end
            for (int c = 0; c < COUNT_CHANNELS; c++) begin
                if (ctrl_write && wb_dat_i[1]) begin
                    model_cnt[c] <= '0;
                end else if (drain) begin
                    model_cnt[c] <= model_cnt[c] + pend_inc[c];
                end
            end
        end
    end

    always_comb begin
        exp_rd = '0;
        for (int i = 0; i < LED_COUNT; i++) begin
            exp_led[i] = (model_cnt[i] != '0);
        end
        if (wb_adr_i[7:6] == SEL_CONVERTER) begin
            if (wb_adr_i[5:0] == CONV_REG_MISSED) begin
                exp_rd = model_missed;
            end else if (wb_adr_i[5:0] == CONV_REG_WRAP) begin
                exp_rd = model_wrap;
            end
        end else if (wb_adr_i[7:6] == SEL_COUNTER) begin
            if (wb_adr_i[5:0] < 6'(COUNT_CHANNELS)) begin
                exp_rd = model_cnt[wb_adr_i[2:0]];
            end else if (wb_adr_i[5:0] == CNT_REG_CONTROL) begin
                exp_rd = {31'b0, model_hold};
            end
        end
    end

    a_reset_state: assert property (@(posedge okClk)
        $rose(rst_n_i) |-> !wb_ack_o && led_o == '0 && s_tready_o)
        else begin
            $error("[FAIL] t=%0t wb_ack_o/led_o/s_tready_o=%b/%b/%b expected 0/0/1",
                   $time, $sampled(wb_ack_o), $sampled(led_o), $sampled(s_tready_o));
            error_count++;
        end

    a_ack_next: assert property (@(posedge okClk) disable iff (!rst_n_i)
        wb_cyc_i && wb_stb_i && !wb_ack_o |=> wb_ack_o)
        else begin
            $error("[FAIL] t=%0t wb_ack_o=0 expected 1", $time);
            error_count++;
        end

    a_ack_single: assert property (@(posedge okClk) disable iff (!rst_n_i)
        wb_ack_o |=> !wb_ack_o)
        else begin
            $error("[FAIL] t=%0t wb_ack_o=1 expected 0", $time);
            error_count++;
        end

    a_read_data: assert property (@(posedge okClk) disable iff (!rst_n_i)
        wb_ack_o && !wb_we_i |-> wb_dat_o == exp_rd)
        else begin
            $error("[FAIL] t=%0t wb_dat_o=%h expected %h at adr %h", $time,
                   $sampled(wb_dat_o), $sampled(exp_rd), $sampled(wb_adr_i));
            error_count++;
        end

    a_leds: assert property (@(posedge okClk) disable iff (!rst_n_i)
        led_o == exp_led)
        else begin
            $error("[FAIL] t=%0t led_o=%b expected %b", $time,
                   $sampled(led_o), $sampled(exp_led));
            error_count++;
        end

    a_ready: assert property (@(posedge okClk) disable iff (!rst_n_i)
        s_tready_o == (!pend_valid || !model_hold))
        else begin
            $error("[FAIL] t=%0t s_tready_o=%b expected %b", $time,
                   $sampled(s_tready_o), !$sampled(pend_valid) || !$sampled(model_hold));
            error_count++;
        end

endmodule

bind tag_link_top tag_link_asserts tag_link_asserts_i (.*);

// ==== verif/tag_link_tb.sv ====
////////////////////
// Testbench for the tag link receive side: clock,
// reset, LFSR tag stream and register traffic
////////////////////

`timescale 1ns/1ps

module tag_link_tb import tag_link_pkg::*; ();

    logic                           okClk;
    logic                           rst_n_i;
    logic                           s_tvalid_i;
    logic                           s_tready_o;
    logic [WORD_WIDTH*TAG_BITS-1:0] s_tdata_i;
    logic [WORD_WIDTH-1:0]          s_tkeep_i;
    logic [WRAP_BITS-1:0]           s_tuser_i;
    logic                           wb_cyc_i;
    logic                           wb_stb_i;
    logic                           wb_we_i;
    logic [WB_ADR_BITS-1:0]         wb_adr_i;
    logic [WB_DATA_BITS-1:0]        wb_dat_i;
    logic [WB_DATA_BITS-1:0]        wb_dat_o;
    logic                           wb_ack_o;
    logic [LED_COUNT-1:0]           led_o;
    logic [15:0]                    lfsr;
    logic [WRAP_BITS-1:0]           wrap_count;
    int unsigned                    cycle_count = 0;

    tag_link_top tag_link_top_i (.*);

    initial begin
        okClk = 1'b0;
        forever #50 okClk = ~okClk;
    end

    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int b = 0; b < n; b++) begin
            lfsr = lfsr_step(lfsr);
            bits = {bits[30:0], lfsr[0]};
        end
    endtask

    // About one word in eight is a marker; most events land on counted channels
    task automatic make_word(output logic [TAG_BITS-1:0] word);
        logic [31:0] pick;
        logic [31:0] field;
        take_bits(3, pick);
        word = '0;
        if (pick == 32'd7) begin
            take_bits(8, field);
            word = {1'b1, 31'(field)};
        end else begin
            take_bits(1, field);
            word[30] = field[0];
            take_bits(1, pick);
            take_bits(pick[0] ? 5 : 3, field);
            word[29:25] = field[4:0];
            take_bits(SUBTIME_BITS, field);
            word[24:0] = field[24:0];
        end
    endtask

    task automatic present_beat();
        logic [TAG_BITS-1:0] lo_word;
        logic [TAG_BITS-1:0] hi_word;
        logic [31:0]         keep;
        make_word(lo_word);
        make_word(hi_word);
        take_bits(2, keep);
        wrap_count = wrap_count + 1'b1;
        s_tvalid_i <= 1'b1;
        s_tdata_i  <= {hi_word, lo_word};
        s_tkeep_i  <= keep[1:0];
        s_tuser_i  <= wrap_count;
    endtask

    // Ready only changes on a rising edge, so the falling edge sees it settled
    task automatic finish_beat();
        @(negedge okClk);
        while (!s_tready_o) begin
            @(negedge okClk);
        end
        @(posedge okClk);
    endtask

    task automatic stream_burst(input int beats);
        logic [31:0] gap;
        for (int n = 0; n < beats; n++) begin
            take_bits(2, gap);
            if (gap == 32'd0) begin
                s_tvalid_i <= 1'b0;
                @(posedge okClk);
            end
            present_beat();
            finish_beat();
        end
        s_tvalid_i <= 1'b0;
    endtask

    // Feed beats under hold until one event beat is parked and ready drops
    task automatic stall_stream();
        logic stalled;
        stalled = 1'b0;
        while (!stalled) begin
            present_beat();
            finish_beat();
            s_tvalid_i <= 1'b0;
            @(negedge okClk);
            stalled = !s_tready_o;
            @(posedge okClk);
        end
    endtask

    task automatic bus_access(input logic we, input logic [WB_ADR_BITS-1:0] adr,
                              input logic [WB_DATA_BITS-1:0] data);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= we;
        wb_adr_i <= adr;
        wb_dat_i <= data;
        @(negedge okClk);
        while (!wb_ack_o) begin
            @(negedge okClk);
        end
        @(posedge okClk);
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
        @(posedge okClk);
    endtask

    task automatic write_reg(input logic [WB_ADR_BITS-1:0] adr,
                             input logic [WB_DATA_BITS-1:0] data);
        bus_access(1'b1, adr, data);
    endtask

    task automatic read_reg(input logic [WB_ADR_BITS-1:0] adr);
        bus_access(1'b0, adr, '0);
    endtask

    // Read data is compared by the bound checker on every ack
    task automatic read_all_regs();
        for (int c = 0; c < COUNT_CHANNELS; c++) begin
            read_reg({SEL_COUNTER, 6'(c)});
        end
        read_reg({SEL_COUNTER, CNT_REG_CONTROL});
        read_reg({SEL_CONVERTER, CONV_REG_MISSED});
        read_reg({SEL_CONVERTER, CONV_REG_WRAP});
        read_reg(8'h80);
        read_reg(8'hC5);
    endtask

    always @(negedge okClk) begin
        if (tag_link_top_i.tag_link_asserts_i.error_count != 0) begin
            $display("ERRORS FOUND");
            $fatal(1, "A bound assertion reported a mismatch");
        end
    end

    // About 1500 beats plus register traffic stay well under this limit
    always @(posedge okClk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == 20000) begin
            $display("ERRORS FOUND");
            $fatal(1, "Timeout, the run did not finish within 20000 cycles");
        end
    end

    initial begin
        rst_n_i    = 1'b0;
        s_tvalid_i = 1'b0;
        s_tdata_i  = '0;
        s_tkeep_i  = '0;
        s_tuser_i  = '0;
        wb_cyc_i   = 1'b0;
        wb_stb_i   = 1'b0;
        wb_we_i    = 1'b0;
        wb_adr_i   = '0;
        wb_dat_i   = '0;
        lfsr       = 16'd40725;
        wrap_count = '0;
        repeat (4) @(posedge okClk);
        rst_n_i <= 1'b1;
        @(posedge okClk);

        read_all_regs();
        stream_burst(600);
        read_all_regs();

        // Hold parks one beat in the converter, release lets it through
        write_reg({SEL_COUNTER, CNT_REG_CONTROL}, 32'h1);
        stall_stream();
        read_reg({SEL_COUNTER, CNT_REG_CONTROL});
        write_reg({SEL_COUNTER, CNT_REG_CONTROL}, 32'h0);
        stream_burst(400);
        read_all_regs();

        write_reg({SEL_COUNTER, CNT_REG_CONTROL}, 32'h2);
        read_all_regs();
        stream_burst(500);
        read_all_regs();
        write_reg(8'hC0, 32'hFFFF_FFFF);
        repeat (2) @(posedge okClk);

        if (tag_link_top_i.tag_link_asserts_i.error_count == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("ERRORS FOUND");
            $fatal(1, "Checks failed during the run");
        end
    end

endmodule

// ==== time_tag_link.f ====
logic/tag_link_pkg.sv
logic/tag_event_if.sv
logic/wb_bus_if.sv
logic/tag_converter.sv
logic/edge_counter.sv
logic/wb_decoder.sv
logic/tag_link_top.sv
verif/tag_link_asserts.sv
verif/tag_link_tb.sv

// ==== Bender.yml ====
package:
  name: time_tag_link

sources:
  - logic/tag_link_pkg.sv
  - logic/tag_event_if.sv
  - logic/wb_bus_if.sv
  - logic/tag_converter.sv
  - logic/edge_counter.sv
  - logic/wb_decoder.sv
  - logic/tag_link_top.sv
  - target: test
    files:
      - verif/tag_link_asserts.sv
      - verif/tag_link_tb.sv
